// File: hw/bubble_cfg.svh
`ifndef BUBBLE_CFG_SVH
`define BUBBLE_CFG_SVH

// bit counts per load phase
`define BOOT_BITS   2656
`define MAP_BITS    1168
`define PREFIX_BITS 6
`define PAGE_BITS   1030

// bubble output buffer start addresses
`define BOOT_BASE   4106
`define PAGE_BASE   14336

// page count of the emulated bubble
`define PAGE_MOD    2053

// flash page with bootloader and bad-loop map
`define BOOT_PAGE   12'h805

// serial flash read opcode
`define FLASH_READ  8'h03

`endif

// File: hw/bubble_pkg.sv
package bubble_pkg;

    typedef logic [2:0]  img_t;         // flash image slot
    typedef logic [11:0] pos_t;         // absolute bubble position
    typedef logic [11:0] page_t;
    typedef logic [2:0]  acc_t;         // emulator access type
    typedef logic [14:0] buf_addr_t;    // bit address in output buffer
    typedef logic [11:0] map_addr_t;
    typedef logic [11:0] bit_cnt_t;

    // {2'b00, image, page, 7'b0}
    typedef logic [23:0] flash_addr_t;

    typedef enum logic [2:0]
    {
        IDLE,
        CMD,
        BOOT,
        MAP,
        PREFIX,
        PAGE,
        DONE
    } load_state_t;

endpackage

// File: hw/spi_bit_if.sv
interface spi_bit_if
    import bubble_pkg::*;
();

    logic        start;        // begin read command
    flash_addr_t flash_addr;
    logic        bit_req;
    logic        bit_valid;
    logic        rx_bit;
    logic        stop;         // release chip select
    logic        ready;        // command word sent

    modport seq
    (
        output start, flash_addr, bit_req, stop,
        input  bit_valid, rx_bit, ready
    );

    modport phy
    (
        input  start, flash_addr, bit_req, stop,
        output bit_valid, rx_bit, ready
    );

endinterface

// File: hw/access_decoder.sv
`include "bubble_cfg.svh"

module access_decoder
    import bubble_pkg::*;
(
    input  logic        MCLK,
    input  logic        rst,
    input  acc_t        acc_type,
    input  pos_t        abs_pos,
    input  img_t        img,
    input  logic        busy,
    output logic        go,
    output logic        is_page,
    output flash_addr_t flash_addr
);

    logic        acc_q;        // last level of access bit 1
    logic        rise;
    logic [12:0] pos_inc;
    page_t       page;
    page_t       sel_page;

    assign rise    = acc_type[1] && !acc_q && !busy;
    assign pos_inc = {1'b0, abs_pos} + 13'd1;   // position advances before the page is fetched

    // single subtraction is enough for positions below the modulus
    assign page = (pos_inc >= 13'(`PAGE_MOD)) ? page_t'(pos_inc - 13'(`PAGE_MOD))
                                              : page_t'(pos_inc);

    assign sel_page = acc_type[0] ? page : `BOOT_PAGE;

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            acc_q   <= 1'b0;
            go      <= 1'b0;
            is_page <= 1'b0;
        end
        else
        begin
            acc_q <= acc_type[1];
            go    <= rise;
            if (rise)
            begin
                is_page    <= acc_type[0];
                flash_addr <= {2'b00, img, sel_page, 7'd0};
            end
        end
    end

endmodule

// File: hw/spi_flash_reader.sv
`include "bubble_cfg.svh"

module spi_flash_reader
(
    input  logic   MCLK,
    input  logic   rst,
    spi_bit_if.phy bus,
    output logic   n_cs,
    output logic   sclk,
    output logic   mosi,
    input  logic   miso
);

    logic [32:0] shreg;        // idle bit, opcode, address
    logic [5:0]  cyc;          // half periods of the command word
    logic        cmd_act;
    logic        req_d1;
    logic        req_d2;

    assign mosi = shreg[32];

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            n_cs          <= 1'b1;
            sclk          <= 1'b1;
            shreg         <= '0;
            cyc           <= '0;
            cmd_act       <= 1'b0;
            req_d1        <= 1'b0;
            req_d2        <= 1'b0;
            bus.ready     <= 1'b0;
            bus.bit_valid <= 1'b0;
        end
        else
        begin
            req_d1        <= bus.bit_req;
            req_d2        <= req_d1;
            bus.bit_valid <= req_d2;
            if (req_d2)
                bus.rx_bit <= miso;     // clock is high here, data is stable

            if (bus.start)
            begin
                n_cs      <= 1'b0;
                shreg     <= {1'b0, `FLASH_READ, bus.flash_addr};
                cyc       <= '0;
                cmd_act   <= 1'b1;
                bus.ready <= 1'b0;
            end
            else if (bus.stop)
            begin
                n_cs      <= 1'b1;
                sclk      <= 1'b1;
                cmd_act   <= 1'b0;
                bus.ready <= 1'b0;
            end
            else if (cmd_act)
            begin
                cyc <= cyc + 6'd1;
                if (!cyc[0])
                begin
                    sclk  <= 1'b0;              // falling edge, next bit out
                    shreg <= {shreg[31:0], 1'b0};
                end
                else
                begin
                    sclk <= 1'b1;
                    if (&cyc)
                    begin
                        cmd_act   <= 1'b0;      // last address bit
                        bus.ready <= 1'b1;
                    end
                end
            end
            else if (bus.bit_req)
                sclk <= 1'b0;
            else if (req_d1)
                sclk <= 1'b1;
        end
    end

endmodule

// File: hw/loop_map_table.sv
module loop_map_table
    import bubble_pkg::*;
(
    input  logic MCLK,
    input  logic rst,
    input  logic map_clr,
    input  logic map_we,
    input  logic map_re,
    input  logic map_wbit,
    output logic map_rbit
);

    logic      map_mem [0:2**$bits(map_addr_t)-1];   // 1 = good loop
    map_addr_t idx;
    map_addr_t widx;

    // map bits arrive with the low nibble inverted
    assign widx = {idx[11:4], ~idx[3:0]};

    always_ff @(posedge MCLK)
    begin
        if (map_we)
            map_mem[widx] <= map_wbit;
        if (map_re)
            map_rbit <= map_mem[idx];
    end

    always_ff @(posedge MCLK)
    begin
        if (rst || map_clr)
            idx <= '0;
        else if (map_we || map_re)
            idx <= idx + map_addr_t'(1);
    end

endmodule

// File: hw/load_sequencer.sv
`include "bubble_cfg.svh"

module load_sequencer
    import bubble_pkg::*;
(
    input  logic        MCLK,
    input  logic        rst,
    input  logic        go,
    input  logic        is_page,
    input  flash_addr_t flash_addr,
    output logic        busy,
    spi_bit_if.seq      bus,
    output logic        map_clr,
    output logic        map_we,
    output logic        map_re,
    output logic        map_wbit,
    input  logic        map_rbit,
    output logic        load_base,
    output buf_addr_t   base,
    output logic        wr,
    output logic        wbit
);

    load_state_t state;
    bit_cnt_t    cnt;
    logic [1:0]  ph;           // map read step in prefix/page
    logic        pend;         // flash bit in flight
    logic        have_bit;     // page bit fetched ahead

    logic        free;
    logic        bit_avail;
    logic        take;
    bit_cnt_t    cnt_nxt;
    logic        req_nxt;

    assign busy      = (state != IDLE);
    assign free      = !pend || bus.bit_valid;
    assign bit_avail = have_bit || bus.bit_valid;
    assign take      = (state == PAGE) && (ph == 2'd2) && map_rbit && bit_avail;

    always_comb
    begin
        cnt_nxt = cnt;
        req_nxt = 1'b0;
        case (state)
            BOOT:
                req_nxt = free;     // boot tail also primes the map
            MAP:
            begin
                cnt_nxt = cnt + bit_cnt_t'(bus.bit_valid);
                req_nxt = free && (cnt_nxt < bit_cnt_t'(`MAP_BITS));
            end
            PAGE:
            begin
                cnt_nxt = cnt + bit_cnt_t'(take);
                req_nxt = free && !(bit_avail && !take) && (cnt_nxt < bit_cnt_t'(`PAGE_BITS));
            end
            default:
                req_nxt = 1'b0;
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            state       <= IDLE;
            cnt         <= '0;
            ph          <= 2'd0;
            pend        <= 1'b0;
            have_bit    <= 1'b0;
            bus.start   <= 1'b0;
            bus.stop    <= 1'b0;
            bus.bit_req <= 1'b0;
            map_clr     <= 1'b0;
            map_we      <= 1'b0;
            map_re      <= 1'b0;
            load_base   <= 1'b0;
            wr          <= 1'b0;
        end
        else
        begin
            bus.start   <= 1'b0;
            bus.stop    <= 1'b0;
            map_clr     <= 1'b0;
            map_we      <= 1'b0;
            map_re      <= 1'b0;
            load_base   <= 1'b0;
            wr          <= 1'b0;
            bus.bit_req <= req_nxt;
            pend        <= (pend && !bus.bit_valid) || req_nxt;
            have_bit    <= (state == PAGE) && bit_avail && !take;

            case (state)
                IDLE:
                    if (go)
                    begin
                        bus.start      <= 1'b1;
                        bus.flash_addr <= flash_addr;
                        map_clr        <= 1'b1;
                        load_base      <= 1'b1;
                        base           <= is_page ? buf_addr_t'(`PAGE_BASE)
                                                  : buf_addr_t'(`BOOT_BASE);
                        cnt            <= '0;
                        ph             <= 2'd0;
                        state          <= CMD;
                    end
                CMD:
                    if (bus.ready)
                        state <= is_page ? PREFIX : BOOT;
                BOOT:
                    if (bus.bit_valid)
                    begin
                        wr   <= 1'b1;
                        wbit <= bus.rx_bit;
                        cnt  <= cnt + bit_cnt_t'(1);
                        if (cnt == bit_cnt_t'(`BOOT_BITS - 1))
                        begin
                            cnt   <= '0;
                            state <= MAP;   // buffer address runs on
                        end
                    end
                MAP:
                    if (bus.bit_valid)
                    begin
                        wr       <= 1'b1;
                        wbit     <= bus.rx_bit;
                        map_we   <= 1'b1;
                        map_wbit <= bus.rx_bit;
                        cnt      <= cnt_nxt;
                        if (cnt == bit_cnt_t'(`MAP_BITS - 1))
                            state <= DONE;
                    end
                PREFIX, PAGE:
                    case (ph)
                        2'd0:
                        begin
                            map_re <= 1'b1;
                            ph     <= 2'd1;
                        end
                        2'd1:
                            ph <= 2'd2;
                        default:
                            if (!map_rbit)
                            begin
                                wr   <= 1'b1;
                                wbit <= 1'b0;       // bad loop, no flash bit used
                                ph   <= 2'd0;
                            end
                            else if (state == PREFIX)
                            begin
                                wr   <= 1'b1;
                                wbit <= 1'b1;
                                ph   <= 2'd0;
                                cnt  <= cnt + bit_cnt_t'(1);
                                if (cnt == bit_cnt_t'(`PREFIX_BITS - 1))
                                begin
                                    cnt   <= '0;
                                    state <= PAGE;
                                end
                            end
                            else if (take)
                            begin
                                wr   <= 1'b1;
                                wbit <= bus.rx_bit;  // reader holds it until the next request
                                ph   <= 2'd0;
                                cnt  <= cnt_nxt;
                                if (cnt == bit_cnt_t'(`PAGE_BITS - 1))
                                    state <= DONE;
                            end
                    endcase
                default:
                begin
                    bus.stop <= 1'b1;
                    state    <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/buffer_writer.sv
module buffer_writer
    import bubble_pkg::*;
(
    input  logic      MCLK,
    input  logic      rst,
    input  logic      load_base,
    input  buf_addr_t base,
    input  logic      wr,
    input  logic      wbit,
    output logic      buf_we_n,
    output buf_addr_t buf_addr,
    output logic      buf_data
);

    always_ff @(posedge MCLK)
    begin
        if (rst)
        begin
            buf_we_n <= 1'b1;
            buf_addr <= '0;
        end
        else
        begin
            buf_we_n <= !wr;                // strobe one cycle after wr
            if (wr)
                buf_data <= wbit;
            if (load_base)
                buf_addr <= base;
            else if (!buf_we_n)
                buf_addr <= buf_addr + buf_addr_t'(1);   // step once strobe ends
        end
    end

endmodule

// File: hw/spi_loader_top.sv
module spi_loader_top
    import bubble_pkg::*;
(
    input  logic      MCLK,
    input  logic      rst,
    input  img_t      IMGNUM,
    input  acc_t      ACCTYPE,
    input  pos_t      ABSPOS,
    output logic      nOUTBUFWCLKEN,
    output buf_addr_t OUTBUFWADDR,
    output logic      OUTBUFWDATA,
    output logic      nCS,
    output logic      CLK,
    output logic      MOSI,
    input  logic      MISO
);

    logic        go;
    logic        is_page;
    flash_addr_t flash_addr;
    logic        busy;
    logic        map_clr;
    logic        map_we;
    logic        map_re;
    logic        map_wbit;
    logic        map_rbit;
    logic        load_base;
    buf_addr_t   base;
    logic        wr;
    logic        wbit;

    spi_bit_if spi_bus ();

    access_decoder dec0
    (
        .MCLK       (MCLK),
        .rst        (rst),
        .acc_type   (ACCTYPE),
        .abs_pos    (ABSPOS),
        .img        (IMGNUM),
        .busy       (busy),
        .go         (go),
        .is_page    (is_page),
        .flash_addr (flash_addr)
    );

    load_sequencer seq0
    (
        .MCLK       (MCLK),
        .rst        (rst),
        .go         (go),
        .is_page    (is_page),
        .flash_addr (flash_addr),
        .busy       (busy),
        .bus        (spi_bus.seq),
        .map_clr    (map_clr),
        .map_we     (map_we),
        .map_re     (map_re),
        .map_wbit   (map_wbit),
        .map_rbit   (map_rbit),
        .load_base  (load_base),
        .base       (base),
        .wr         (wr),
        .wbit       (wbit)
    );

    spi_flash_reader spi0
    (
        .MCLK (MCLK),
        .rst  (rst),
        .bus  (spi_bus.phy),
        .n_cs (nCS),
        .sclk (CLK),
        .mosi (MOSI),
        .miso (MISO)
    );

    loop_map_table map0
    (
        .MCLK     (MCLK),
        .rst      (rst),
        .map_clr  (map_clr),
        .map_we   (map_we),
        .map_re   (map_re),
        .map_wbit (map_wbit),
        .map_rbit (map_rbit)
    );

    buffer_writer buf0
    (
        .MCLK      (MCLK),
        .rst       (rst),
        .load_base (load_base),
        .base      (base),
        .wr        (wr),
        .wbit      (wbit),
        .buf_we_n  (nOUTBUFWCLKEN),
        .buf_addr  (OUTBUFWADDR),
        .buf_data  (OUTBUFWDATA)
    );

endmodule

// File: tests/flash_model.sv
module flash_model
    import bubble_pkg::*;
(
    input  logic        n_cs,
    input  logic        sclk,
    input  logic        mosi,
    output logic        miso,
    output logic [7:0]  opcode,
    output flash_addr_t addr
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STREAM_BITS = 4096;

    logic        data_bits [0:STREAM_BITS-1];  // stream content, filled by the testbench
    logic [31:0] cmd_sr  = '0;
    int          cmd_cnt = 0;                  // command bits seen since chip select fell
    int          ptr     = 0;                  // next stream bit

    initial
    begin
        miso   = 1'b0;
        opcode = '0;
        addr   = '0;
    end

    // command and address come in MSB first on rising edges
    always @(posedge sclk or posedge n_cs)
    begin
        if (n_cs)
            cmd_cnt = 0;
        else if (cmd_cnt < 32)
        begin
            cmd_sr  = {cmd_sr[30:0], mosi};
            cmd_cnt = cmd_cnt + 1;
            if (cmd_cnt == 32)
            begin
                opcode = cmd_sr[31:24];
                addr   = cmd_sr[23:0];
            end
        end
    end

    // every access restarts the stream at bit 0
    always @(negedge sclk or posedge n_cs)
    begin
        if (n_cs)
            ptr = 0;
        else if (cmd_cnt == 32 && ptr < STREAM_BITS)
        begin
            miso <= data_bits[ptr];   // master samples on the next rise
            ptr = ptr + 1;
        end
    end

endmodule

// File: tests/tb_spi_loader.sv
`include "bubble_cfg.svh"

module tb_spi_loader
    import bubble_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CMD_CYCLES   = 70;
    localparam int LIMIT_CYCLES = 2 * 4 * ((`BOOT_BITS + `MAP_BITS) * 4
                                           + (`PREFIX_BITS + `PAGE_BITS) * 4 + CMD_CYCLES);

    logic        MCLK = 1'b0;
    logic        rst;
    img_t        IMGNUM;
    acc_t        ACCTYPE;
    pos_t        ABSPOS;
    logic        nOUTBUFWCLKEN;
    buf_addr_t   OUTBUFWADDR;
    logic        OUTBUFWDATA;
    logic        nCS;
    logic        CLK;
    logic        MOSI;
    logic        MISO;
    logic [7:0]  flash_op;
    flash_addr_t flash_adr;

    logic        shadow [0:2**15-1];   // buffer image built from strobes
    logic        smap   [0:4095];      // expected loop map
    logic [31:0] lfsr = 32'h4c32;
    int          errors    = 0;
    int          checks    = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          n_writes  = 0;
    int          n_outside = 0;
    int          acc_w0;
    int          acc_o0;
    buf_addr_t   win_lo = '0;
    buf_addr_t   win_hi = '0;

    always #4 MCLK = !MCLK;

    spi_loader_top dut0
    (
        .MCLK          (MCLK),
        .rst           (rst),
        .IMGNUM        (IMGNUM),
        .ACCTYPE       (ACCTYPE),
        .ABSPOS        (ABSPOS),
        .nOUTBUFWCLKEN (nOUTBUFWCLKEN),
        .OUTBUFWADDR   (OUTBUFWADDR),
        .OUTBUFWDATA   (OUTBUFWDATA),
        .nCS           (nCS),
        .CLK           (CLK),
        .MOSI          (MOSI),
        .MISO          (MISO)
    );

    flash_model flash0
    (
        .n_cs   (nCS),
        .sclk   (CLK),
        .mosi   (MOSI),
        .miso   (MISO),
        .opcode (flash_op),
        .addr   (flash_adr)
    );

    // strobe is low for one whole cycle
    always @(negedge MCLK)
    begin
        if (nOUTBUFWCLKEN === 1'b0)
        begin
            shadow[OUTBUFWADDR] <= OUTBUFWDATA;
            n_writes            <= n_writes + 1;
            if (OUTBUFWADDR < win_lo || OUTBUFWADDR > win_hi)
                n_outside <= n_outside + 1;
        end
    end

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge MCLK);
        $display("watchdog: run did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b    = lfsr[0];
    endtask

    task automatic report_mismatch(input string name, input string got, input string exp);
        errors++;
        $display("[FAIL] t=%0d ns %s: got %s, expected %s", $time, name, got, exp);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_buf_addr(input string name, input buf_addr_t got, input buf_addr_t exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_addr(input string name, input flash_addr_t got, input flash_addr_t exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, $sformatf("%06h", got), $sformatf("%06h", exp));
    endtask

    task automatic check_op(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, $sformatf("%02h", got), $sformatf("%02h", exp));
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors == err0)
            $display("[ OK ] %s", name);
        else
        begin
            tests_bad++;
            $display("[BAD ] %s, %0d errors", name, errors - err0);
        end
    endtask

    task automatic start_access(input logic page_acc, input img_t img, input pos_t pos);
        @(negedge MCLK);
        acc_w0  = n_writes;
        acc_o0  = n_outside;
        IMGNUM  = img;
        ABSPOS  = pos;
        ACCTYPE = {1'b0, 1'b1, page_acc};   // bit 1 starts, bit 0 selects page
        @(negedge nCS);
    endtask

    // level stays high a while, no new access may start from it
    task automatic wait_done();
        int stray;
        stray = 0;
        @(posedge nCS);
        repeat (80)
        begin
            @(negedge MCLK);
            if (nCS !== 1'b1)
                stray++;
        end
        if (stray != 0)
            report_problem("chip select fell again without a new ACCTYPE rise");
        ACCTYPE = 3'b000;
        @(negedge MCLK);
    endtask

    task automatic check_counts(input int base, input int n);
        check_buf_addr("write count", buf_addr_t'(n_writes - acc_w0), buf_addr_t'(n));
        check_buf_addr("OUTBUFWADDR", OUTBUFWADDR, buf_addr_t'(base + n));
        check_bit("nCS", nCS, 1'b1);
        if (n_outside != acc_o0)
            report_problem($sformatf("%0d writes landed outside the loaded range",
                                     n_outside - acc_o0));
    endtask

    // bootloader bits then map bits, map optionally with bad loops
    task automatic boot_access(input img_t img, input logic with_bad);
        logic      b;
        int        bad;
        map_addr_t mi;
        bad = 0;
        for (int i = 0; i < `BOOT_BITS; i++)
        begin
            next_bit(b);
            flash0.data_bits[i] = b;
        end
        for (int i = 0; i < `MAP_BITS; i++)
        begin
            b = 1'b1;
            if (with_bad)
            begin
                for (int t = 0; t < 4; t++)
                begin
                    next_bit(b);
                    if (b)
                        break;
                end
                b = (b || bad >= 100) && (i != 15);   // index 15 lands on entry 0
                bad += !b;
            end
            flash0.data_bits[`BOOT_BITS + i] = b;
            mi = map_addr_t'(i);
            smap[{mi[11:4], ~mi[3:0]}] = b;
        end
        win_lo = buf_addr_t'(`BOOT_BASE);
        win_hi = buf_addr_t'(`BOOT_BASE + `BOOT_BITS + `MAP_BITS - 1);
        start_access(1'b0, img, 12'd0);
        wait_done();
        check_op("flash opcode", flash_op, `FLASH_READ);
        check_addr("flash address", flash_adr, {2'b00, img, `BOOT_PAGE, 7'd0});
        for (int i = 0; i < `BOOT_BITS; i++)
            check_bit($sformatf("buffer[%0d]", `BOOT_BASE + i), shadow[`BOOT_BASE + i],
                      flash0.data_bits[i]);
    endtask

    task automatic check_map_bits();
        int a;
        for (int i = `BOOT_BITS; i < `BOOT_BITS + `MAP_BITS; i++)
        begin
            a = `BOOT_BASE + i;
            check_bit($sformatf("buffer[%0d]", a), shadow[a], flash0.data_bits[i]);
        end
        check_counts(`BOOT_BASE, `BOOT_BITS + `MAP_BITS);
    endtask

    task automatic page_test(input img_t img, input pos_t pos, input logic bump);
        logic  expw [0:2047];
        logic  b;
        int    good;
        int    j;
        int    p;
        int    k;
        page_t pg;
        for (int i = 0; i < `PAGE_BITS + 8; i++)
        begin
            next_bit(b);
            flash0.data_bits[i] = b;
        end
        good = 0;
        j    = 0;
        p    = 0;
        k    = 0;
        while (good < `PREFIX_BITS + `PAGE_BITS)
        begin
            if (!smap[j])
                expw[k] = 1'b0;                     // bad loop
            else if (good < `PREFIX_BITS)
            begin
                expw[k] = 1'b1;
                good++;
            end
            else
            begin
                expw[k] = flash0.data_bits[p];
                p++;
                good++;
            end
            j++;
            k++;
        end
        pg     = page_t'((int'(pos) + 1) % `PAGE_MOD);
        win_lo = buf_addr_t'(`PAGE_BASE);
        win_hi = buf_addr_t'(`PAGE_BASE + k - 1);
        start_access(1'b1, img, pos);
        if (bump)
        begin
            repeat (20) @(negedge MCLK);
            ACCTYPE = 3'b000;
            repeat (2) @(negedge MCLK);
            IMGNUM  = ~img;
            ABSPOS  = ~pos;
            ACCTYPE = 3'b010;   // bootloader rise while the command word is sent
        end
        wait_done();
        check_op("flash opcode", flash_op, `FLASH_READ);
        check_addr("flash address", flash_adr, {2'b00, img, pg, 7'd0});
        for (int i = 0; i < k; i++)
            check_bit($sformatf("buffer[%0d]", `PAGE_BASE + i), shadow[`PAGE_BASE + i], expw[i]);
        check_counts(`PAGE_BASE, k);
    endtask

    task automatic test_reset_idle();
        int err0;
        int w0;
        err0 = errors;
        w0   = n_writes;
        check_bit("nCS", nCS, 1'b1);
        check_bit("CLK", CLK, 1'b1);
        check_bit("nOUTBUFWCLKEN", nOUTBUFWCLKEN, 1'b1);
        repeat (40) @(negedge MCLK);
        check_buf_addr("idle write count", buf_addr_t'(n_writes - w0), '0);
        check_bit("nCS", nCS, 1'b1);
        finish_test("reset state and idle", err0);
    endtask

    initial
    begin
        int err0;
        rst     = 1'b1;
        IMGNUM  = '0;
        ACCTYPE = '0;
        ABSPOS  = '0;
        repeat (5) @(negedge MCLK);
        rst = 1'b0;
        @(negedge MCLK);
        test_reset_idle();
        err0 = errors;
        boot_access(3'd5, 1'b0);
        finish_test("bootloader access, image 5", err0);
        err0 = errors;
        check_map_bits();
        finish_test("bad-loop map bits of the same access", err0);
        err0 = errors;
        page_test(3'd5, 12'd4000, 1'b0);
        finish_test("page access, all-good map, position 4000", err0);
        err0 = errors;
        boot_access(3'd3, 1'b1);
        check_map_bits();
        page_test(3'd3, 12'd777, 1'b0);
        finish_test("page access with bad map entries", err0);
        err0 = errors;
        page_test(3'd2, 12'd100, 1'b1);
        page_test(3'd6, 12'd2052, 1'b0);
        finish_test("ACCTYPE rise while busy is ignored", err0);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/bubble_pkg.sv
hw/spi_bit_if.sv
hw/access_decoder.sv
hw/spi_flash_reader.sv
hw/loop_map_table.sv
hw/load_sequencer.sv
hw/buffer_writer.sv
hw/spi_loader_top.sv
tests/flash_model.sv
tests/tb_spi_loader.sv

// File: Bender.yml
package:
  name: spi_loader

sources:
  - include_dirs:
      - hw
    files:
      - hw/bubble_pkg.sv
      - hw/spi_bit_if.sv
      - hw/access_decoder.sv
      - hw/spi_flash_reader.sv
      - hw/loop_map_table.sv
      - hw/load_sequencer.sv
      - hw/buffer_writer.sv
      - hw/spi_loader_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/flash_model.sv
      - tests/tb_spi_loader.sv
